/* rtl/thumb_params.svh */
////////////////////////////////////////
// Thumb expander parameters
// Widths, extension bit positions and the
// 16-bit opcode match patterns
////////////////////////////////////////

`ifndef THUMB_PARAMS_SVH
`define THUMB_PARAMS_SVH

`define THUMB_W         16              // Compressed instruction
`define ARM_W           32              // Full ARM word
`define EXT_W           3               // Extension above ARM word
`define EXT_SHL1        2               // Ext bit, branch offset shifts by 1
`define BR_OFF_W        24              // ARM branch offset field

`define COND_AL         4'b1110         // Always

////////////////////////////////////////
// Opcode match patterns, casez style
////////////////////////////////////////

`define T_SWI           16'b1101_1111_????_????
`define T_ADD_SUB_LO    16'b0001_1???_????_????
`define T_BX            16'b0100_0111_0???_????
`define T_BRANCH_COND   16'b1101_????_????_????
`define T_BRANCH_NOCOND 16'b1110_0???_????_????
`define T_SHIFT         16'b000?_????_????_????
`define T_MCAS_IMM      16'b001?_????_????_????
`define T_ALU_LO        16'b0100_00??_????_????
`define T_ALU_HI        16'b0100_01??_????_????

`endif

/* rtl/thumb_decoder_pkg.sv */
////////////////////////////////////////
// Thumb decoder types
// ARM opcodes, shift kinds, instruction
// classes and the decode result structs
////////////////////////////////////////

`include "thumb_params.svh"

package thumb_decoder_pkg;

        // ARM data processing opcodes, bits 24:21
        typedef enum logic [3:0]
        {
                OP_AND = 4'd0,
                OP_EOR = 4'd1,
                OP_SUB = 4'd2,
                OP_RSB = 4'd3,
                OP_ADD = 4'd4,
                OP_ADC = 4'd5,
                OP_SBC = 4'd6,
                OP_RSC = 4'd7,
                OP_TST = 4'd8,
                OP_TEQ = 4'd9,
                OP_CMP = 4'd10,
                OP_CMN = 4'd11,
                OP_ORR = 4'd12,
                OP_MOV = 4'd13,
                OP_BIC = 4'd14,
                OP_MVN = 4'd15
        } alu_op_e;

        // Shifter type, bits 6:5
        typedef enum logic [1:0]
        {
                SH_LSL = 2'd0,
                SH_LSR = 2'd1,
                SH_ASR = 2'd2,
                SH_ROR = 2'd3
        } shift_e;

        // What the classifier found
        typedef enum logic [3:0]
        {
                ARM_PASS,       // Not Thumb or no valid
                SHIFT,
                ADD_SUB_LO,
                MCAS_IMM,
                ALU_LO,
                ALU_HI,
                BR_COND,
                BR_UNCOND,
                SWI,
                BX,
                UNDEF           // Traps in the ARM decoder
        } thumb_class_e;

        typedef struct packed
        {
                logic [`EXT_W-1:0] ext;         // MSB set means offset << 1
                logic [`ARM_W-1:0] arm;
        } arm_ext_t;

        typedef struct packed
        {
                logic     valid;
                logic     und;
                arm_ext_t instr;
        } decode_result_t;

endpackage

/* rtl/thumb_classify.sv */
////////////////////////////////////////
// Thumb classifier
// Matches the 16-bit opcode and names
// the instruction class
////////////////////////////////////////

`timescale 1ns/1ps

`include "thumb_params.svh"

module thumb_classify
(
        input  logic [`ARM_W-1:0]               i_instruction,
        input  logic                            i_instruction_valid,
        input  logic                            i_cpsr_ff_t,            // T bit

        output thumb_decoder_pkg::thumb_class_e o_class
);

logic [`THUMB_W-1:0] hw;        // Compressed halfword

assign hw = i_instruction[`THUMB_W-1:0];

////////////////////////////////////////
// Priority match, first hit wins
////////////////////////////////////////

always_comb
begin
        o_class = thumb_decoder_pkg::UNDEF;

        // ARM state or bubble, pass untouched
        if (!i_cpsr_ff_t || !i_instruction_valid)
        begin
                o_class = thumb_decoder_pkg::ARM_PASS;
        end
        else
        begin
                // SWI sits inside cond branch space, so check it first
                casez (hw)
                `T_SWI:           o_class = thumb_decoder_pkg::SWI;
                `T_ADD_SUB_LO:    o_class = thumb_decoder_pkg::ADD_SUB_LO;
                `T_BX:            o_class = thumb_decoder_pkg::BX;
                `T_BRANCH_COND:   o_class = thumb_decoder_pkg::BR_COND;
                `T_BRANCH_NOCOND: o_class = thumb_decoder_pkg::BR_UNCOND;
                `T_SHIFT:         o_class = thumb_decoder_pkg::SHIFT;
                `T_MCAS_IMM:      o_class = thumb_decoder_pkg::MCAS_IMM;
                `T_ALU_LO:        o_class = thumb_decoder_pkg::ALU_LO;
                `T_ALU_HI:
                begin
                        // Op 3 is BX/BLX2 space, BX already taken above
                        if (hw[9:8] != 2'b11)
                                o_class = thumb_decoder_pkg::ALU_HI;
                end
                default:          o_class = thumb_decoder_pkg::UNDEF;   // Loads, BL etc
                endcase
        end
end

endmodule

/* rtl/thumb_dp_expand.sv */
////////////////////////////////////////
// Data processing expander
// Shift, ADD/SUB low, MCAS immediate and
// ALU low/high into ARM DP words
////////////////////////////////////////

`timescale 1ns/1ps

`include "thumb_params.svh"

module thumb_dp_expand
(
        input  logic [`THUMB_W-1:0]             i_halfword,
        input  thumb_decoder_pkg::thumb_class_e i_class,

        output thumb_decoder_pkg::arm_ext_t     o_arm
);

// Register fields
logic [3:0]  rd_lo;             // Bits 2:0
logic [3:0]  rs_lo;             // Bits 5:3
logic [3:0]  rd_imm;            // Bits 10:8, MCAS
logic [3:0]  rd_hi;             // H1 plus bits 2:0
logic [3:0]  rs_hi;             // H2 plus bits 5:3
logic [11:0] reg_op2;           // Plain register operand

thumb_decoder_pkg::alu_op_e mcas_op;
thumb_decoder_pkg::alu_op_e hi_op;
thumb_decoder_pkg::alu_op_e lo_op;
logic                       lo_imm;
logic [3:0]                 lo_rn;
logic [11:0]                lo_op2;
logic [`ARM_W-1:0]          lo_word;
logic [`ARM_W-1:0]          word;

assign rd_lo   = {1'b0, i_halfword[2:0]};
assign rs_lo   = {1'b0, i_halfword[5:3]};
assign rd_imm  = {1'b0, i_halfword[10:8]};
assign rd_hi   = {i_halfword[7], i_halfword[2:0]};
assign rs_hi   = {i_halfword[6], i_halfword[5:3]};
assign reg_op2 = {8'd0, rs_lo};

// AL-conditioned DP word
function automatic logic [`ARM_W-1:0] dp_word
(
        input thumb_decoder_pkg::alu_op_e op,
        input logic                       imm,
        input logic                       s,
        input logic [3:0]                 rn,
        input logic [3:0]                 rd,
        input logic [11:0]                op2
);
        return {`COND_AL, 2'b00, imm, op, s, rn, rd, op2};
endfunction

////////////////////////////////////////
// Opcode selection per group
////////////////////////////////////////

always_comb
begin
        case (i_halfword[12:11])
        2'd0:    mcas_op = thumb_decoder_pkg::OP_MOV;
        2'd1:    mcas_op = thumb_decoder_pkg::OP_CMP;
        2'd2:    mcas_op = thumb_decoder_pkg::OP_ADD;
        default: mcas_op = thumb_decoder_pkg::OP_SUB;
        endcase

        case (i_halfword[9:8])
        2'd0:    hi_op = thumb_decoder_pkg::OP_ADD;
        2'd1:    hi_op = thumb_decoder_pkg::OP_CMP;
        default: hi_op = thumb_decoder_pkg::OP_MOV;     // Op 3 is UNDEF upstream
        endcase
end

// ALU low, sixteen ops, all flag setting
always_comb
begin
        lo_op  = thumb_decoder_pkg::OP_MOV;
        lo_imm = 1'b0;
        lo_rn  = rd_lo;
        lo_op2 = reg_op2;
        case (i_halfword[9:6])
        4'd0:  lo_op  = thumb_decoder_pkg::OP_AND;
        4'd1:  lo_op  = thumb_decoder_pkg::OP_EOR;
        4'd2:  lo_op2 = {rs_lo, 1'b0, thumb_decoder_pkg::SH_LSL, 1'b1, rd_lo};   // Rd LSL Rs
        4'd3:  lo_op2 = {rs_lo, 1'b0, thumb_decoder_pkg::SH_LSR, 1'b1, rd_lo};
        4'd4:  lo_op2 = {rs_lo, 1'b0, thumb_decoder_pkg::SH_ASR, 1'b1, rd_lo};
        4'd5:  lo_op  = thumb_decoder_pkg::OP_ADC;
        4'd6:  lo_op  = thumb_decoder_pkg::OP_SBC;
        4'd7:  lo_op2 = {rs_lo, 1'b0, thumb_decoder_pkg::SH_ROR, 1'b1, rd_lo};
        4'd8:  lo_op  = thumb_decoder_pkg::OP_TST;
        4'd9:
        begin
                // NEG is RSB Rd, Rs, #0
                lo_op  = thumb_decoder_pkg::OP_RSB;
                lo_imm = 1'b1;
                lo_rn  = rs_lo;
                lo_op2 = 12'd0;
        end
        4'd10: lo_op  = thumb_decoder_pkg::OP_CMP;
        4'd11: lo_op  = thumb_decoder_pkg::OP_CMN;
        4'd12: lo_op  = thumb_decoder_pkg::OP_ORR;
        4'd14: lo_op  = thumb_decoder_pkg::OP_BIC;
        4'd15: lo_op  = thumb_decoder_pkg::OP_MVN;
        default: lo_op = thumb_decoder_pkg::OP_MOV;    // MUL handled below
        endcase
end

// MULS Rd, Rs, Rd lives outside DP space
assign lo_word = (i_halfword[9:6] == 4'd13) ?
                 {`COND_AL, 7'b0000_000, 1'b1, rd_lo, 4'd0, rd_lo, 4'b1001, rs_lo} :
                 dp_word(lo_op, lo_imm, 1'b1, lo_rn, rd_lo, lo_op2);

////////////////////////////////////////
// Final word by class
////////////////////////////////////////

always_comb
begin
        case (i_class)
        thumb_decoder_pkg::SHIFT:       // MOVS Rd, Rs, <sh> #imm5
                word = dp_word(thumb_decoder_pkg::OP_MOV, 1'b0, 1'b1, 4'd0, rd_lo,
                               {i_halfword[10:6], i_halfword[12:11], 1'b0, rs_lo});
        thumb_decoder_pkg::ADD_SUB_LO:  // Reg and imm3 share the low field
                word = dp_word(i_halfword[9] ? thumb_decoder_pkg::OP_SUB :
                               thumb_decoder_pkg::OP_ADD,
                               i_halfword[10], 1'b1, rs_lo, rd_lo, {9'd0, i_halfword[8:6]});
        thumb_decoder_pkg::MCAS_IMM:
                word = dp_word(mcas_op, 1'b1, 1'b1, rd_imm, rd_imm, {4'd0, i_halfword[7:0]});
        thumb_decoder_pkg::ALU_LO:
                word = lo_word;
        thumb_decoder_pkg::ALU_HI:      // Only CMP sets flags
                word = dp_word(hi_op, 1'b0, (i_halfword[9:8] == 2'd1), rd_hi, rd_hi,
                               {8'd0, rs_hi});
        default:
                word = '0;
        endcase
end

assign o_arm = {{`EXT_W{1'b0}}, word};  // No extension for DP

endmodule

/* rtl/thumb_branch_expand.sv */
////////////////////////////////////////
// Branch expander
// B, B<cond>, SWI and BX into ARM words
////////////////////////////////////////

`timescale 1ns/1ps

`include "thumb_params.svh"

module thumb_branch_expand
(
        input  logic [`THUMB_W-1:0]             i_halfword,
        input  thumb_decoder_pkg::thumb_class_e i_class,

        output thumb_decoder_pkg::arm_ext_t     o_arm
);

localparam logic [`EXT_W-1:0] ext_shl1 = 1 << `EXT_SHL1;       // Halfword offset marker

logic [`BR_OFF_W-1:0] off_cond;         // Sign extended imm8
logic [`BR_OFF_W-1:0] off_uncond;       // Sign extended imm11

assign off_cond   = {{(`BR_OFF_W-8){i_halfword[7]}}, i_halfword[7:0]};
assign off_uncond = {{(`BR_OFF_W-11){i_halfword[10]}}, i_halfword[10:0]};

always_comb
begin
        o_arm = '0;
        case (i_class)
        thumb_decoder_pkg::BR_COND:
        begin
                o_arm.ext = ext_shl1;
                o_arm.arm = {i_halfword[11:8], 3'b101, 1'b0, off_cond};  // B<cond>, no link
        end
        thumb_decoder_pkg::BR_UNCOND:
        begin
                o_arm.ext = ext_shl1;
                o_arm.arm = {`COND_AL, 3'b101, 1'b0, off_uncond};
        end
        thumb_decoder_pkg::SWI:
                o_arm.arm = {`COND_AL, 4'b1111, 16'd0, i_halfword[7:0]};  // Comment byte
        thumb_decoder_pkg::BX:
                o_arm.arm = {`COND_AL, 24'h12_FFF1, i_halfword[6:3]};     // Rm incl high regs
        default:
                o_arm = '0;
        endcase
end

endmodule

/* rtl/thumb_decode_reg.sv */
////////////////////////////////////////
// Decode output stage
// Picks the expanded word by class and
// registers it for one cycle
////////////////////////////////////////

`timescale 1ns/1ps

`include "thumb_params.svh"

module thumb_decode_reg
(
        input  logic                              i_clk,
        input  logic                              i_rst_n,
        input  logic                              i_valid,
        input  logic [`ARM_W-1:0]                 i_instruction,  // Raw word
        input  thumb_decoder_pkg::thumb_class_e   i_class,
        input  thumb_decoder_pkg::arm_ext_t       i_dp,
        input  thumb_decoder_pkg::arm_ext_t       i_br,

        output thumb_decoder_pkg::decode_result_t o_result
);

thumb_decoder_pkg::arm_ext_t sel;

always_comb
begin
        case (i_class)
        thumb_decoder_pkg::SHIFT,
        thumb_decoder_pkg::ADD_SUB_LO,
        thumb_decoder_pkg::MCAS_IMM,
        thumb_decoder_pkg::ALU_LO,
        thumb_decoder_pkg::ALU_HI:    sel = i_dp;
        thumb_decoder_pkg::BR_COND,
        thumb_decoder_pkg::BR_UNCOND,
        thumb_decoder_pkg::SWI,
        thumb_decoder_pkg::BX:        sel = i_br;
        default:                      sel = {{`EXT_W{1'b0}}, i_instruction};   // Pass or UND
        endcase
end

// Decode stage register
always_ff @(posedge i_clk)
begin
        if (!i_rst_n)
                o_result <= '0;
        else
        begin
                o_result.valid <= i_valid;
                o_result.und   <= (i_class == thumb_decoder_pkg::UNDEF);
                o_result.instr <= sel;
        end
end

endmodule

/* rtl/thumb_decoder_top.sv */
////////////////////////////////////////
// Thumb decoder top
// Classify, expand, register one cycle
////////////////////////////////////////

`timescale 1ns/1ps

`include "thumb_params.svh"

module thumb_decoder_top
(
        input  logic                     i_clk,
        input  logic                     i_rst_n,
        input  logic [`ARM_W-1:0]        i_instruction,
        input  logic                     i_instruction_valid,
        input  logic                     i_cpsr_ff_t,

        output logic [`EXT_W+`ARM_W-1:0] o_instruction,      // Ext plus ARM word
        output logic                     o_instruction_valid,
        output logic                     o_und
);

thumb_decoder_pkg::thumb_class_e   cls;
thumb_decoder_pkg::arm_ext_t       dp_arm;         // DP candidate
thumb_decoder_pkg::arm_ext_t       br_arm;         // Branch candidate
thumb_decoder_pkg::decode_result_t result;

thumb_classify u_classify
(
        .i_instruction       (i_instruction),
        .i_instruction_valid (i_instruction_valid),
        .i_cpsr_ff_t         (i_cpsr_ff_t),
        .o_class             (cls)
);

thumb_dp_expand u_dp_expand
(
        .i_halfword (i_instruction[`THUMB_W-1:0]),
        .i_class    (cls),
        .o_arm      (dp_arm)
);

thumb_branch_expand u_branch_expand
(
        .i_halfword (i_instruction[`THUMB_W-1:0]),
        .i_class    (cls),
        .o_arm      (br_arm)
);

thumb_decode_reg u_decode_reg
(
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_valid       (i_instruction_valid),
        .i_instruction (i_instruction),
        .i_class       (cls),
        .i_dp          (dp_arm),
        .i_br          (br_arm),
        .o_result      (result)
);

// Split the registered result
assign o_instruction       = result.instr;
assign o_instruction_valid = result.valid;
assign o_und               = result.und;

endmodule

/* tb/thumb_ref_model.svh */
////////////////////////////////////////
// Thumb reference model
// Expected extended ARM words built from
// the ARM encoding rules
////////////////////////////////////////

`ifndef THUMB_REF_MODEL_SVH
`define THUMB_REF_MODEL_SVH

// cond 00 I opcode S Rn Rd operand2
function automatic logic [31:0] arm_dp
(
        input logic [3:0]  op,
        input logic        imm,
        input logic        s,
        input logic [3:0]  rn,
        input logic [3:0]  rd,
        input logic [11:0] op2
);
        arm_dp = {`COND_AL, 2'b00, imm, op, s, rn, rd, op2};
endfunction

// MOVS Rd, Rs, <type> #imm5
function automatic logic [34:0] exp_shift(input logic [15:0] hw);
        exp_shift = {3'b000, arm_dp(4'd13, 1'b0, 1'b1, 4'd0, {1'b0, hw[2:0]},
                                    {hw[10:6], hw[12:11], 1'b0, 1'b0, hw[5:3]})};
endfunction

// Bit 10 picks imm3, bit 9 picks SUB
function automatic logic [34:0] exp_add_sub(input logic [15:0] hw);
        exp_add_sub = {3'b000, arm_dp(hw[9] ? 4'd2 : 4'd4, hw[10], 1'b1, {1'b0, hw[5:3]},
                                      {1'b0, hw[2:0]}, {9'd0, hw[8:6]})};
endfunction

function automatic logic [34:0] exp_mcas(input logic [15:0] hw);
        logic [3:0] op;
        op       = (hw[12:11] == 2'd0) ? 4'd13 : (hw[12:11] == 2'd1) ? 4'd10 :
                   (hw[12:11] == 2'd2) ? 4'd4 : 4'd2;     // MOV CMP ADD SUB
        exp_mcas = {3'b000, arm_dp(op, 1'b1, 1'b1, {1'b0, hw[10:8]}, {1'b0, hw[10:8]},
                                   {4'd0, hw[7:0]})};
endfunction

function automatic logic [34:0] exp_alu_lo(input logic [15:0] hw);
        logic [3:0]  rd;
        logic [3:0]  rs;
        logic [31:0] w;
        rd = {1'b0, hw[2:0]};
        rs = {1'b0, hw[5:3]};
        case (hw[9:6])
        4'd2:  w = arm_dp(4'd13, 1'b0, 1'b1, rd, rd, {rs, 1'b0, 2'd0, 1'b1, rd});  // LSL
        4'd3:  w = arm_dp(4'd13, 1'b0, 1'b1, rd, rd, {rs, 1'b0, 2'd1, 1'b1, rd});
        4'd4:  w = arm_dp(4'd13, 1'b0, 1'b1, rd, rd, {rs, 1'b0, 2'd2, 1'b1, rd});
        4'd7:  w = arm_dp(4'd13, 1'b0, 1'b1, rd, rd, {rs, 1'b0, 2'd3, 1'b1, rd});  // ROR
        4'd9:  w = arm_dp(4'd3, 1'b1, 1'b1, rs, rd, 12'd0);                       // NEG
        4'd13: w = {`COND_AL, 6'd0, 1'b0, 1'b1, rd, 4'd0, rd, 4'b1001, rs};      // MULS
        default:
                w = arm_dp(hw[9:6], 1'b0, 1'b1, rd, rd, {8'd0, rs});  // Same op number
        endcase
        exp_alu_lo = {3'b000, w};
endfunction

function automatic logic [34:0] exp_alu_hi(input logic [15:0] hw);
        logic [3:0] op;
        op         = (hw[9:8] == 2'd0) ? 4'd4 : (hw[9:8] == 2'd1) ? 4'd10 : 4'd13;
        exp_alu_hi = {3'b000, arm_dp(op, 1'b0, hw[9:8] == 2'd1, {hw[7], hw[2:0]},
                                     {hw[7], hw[2:0]}, {8'd0, hw[6], hw[5:3]})};
endfunction

// Ext MSB marks a halfword offset
function automatic logic [34:0] exp_branch_cond(input logic [15:0] hw);
        exp_branch_cond = {3'b100, hw[11:8], 4'b1010, {16{hw[7]}}, hw[7:0]};
endfunction

function automatic logic [34:0] exp_branch_uncond(input logic [15:0] hw);
        exp_branch_uncond = {3'b100, `COND_AL, 4'b1010, {13{hw[10]}}, hw[10:0]};
endfunction

function automatic logic [34:0] exp_swi(input logic [15:0] hw);
        exp_swi = {3'b000, `COND_AL, 4'b1111, 16'd0, hw[7:0]};
endfunction

function automatic logic [34:0] exp_bx(input logic [15:0] hw);
        exp_bx = {3'b000, `COND_AL, 24'h12_FFF1, hw[6:3]};      // Rm incl high bit
endfunction

`endif

/* tb/tb_thumb_decoder.sv */
////////////////////////////////////////
// Thumb decoder testbench
// Directed tests against the reference
// model, one cycle latency
////////////////////////////////////////

`timescale 1ns/1ps

`include "thumb_params.svh"

module tb_thumb_decoder;

localparam int test_cycles = 125;               // Rough length of all tests
localparam int cycle_limit = 4 * test_cycles;

logic        clk;
logic        rst_n;
logic [31:0] instr;
logic        instr_valid;
logic        cpsr_t;
logic [34:0] out_instr;
logic        out_valid;
logic        out_und;
int          cycle_count;
int          seed;

thumb_decoder_top u_thumb_decoder_top
(
        .i_clk               (clk),
        .i_rst_n             (rst_n),
        .i_instruction       (instr),
        .i_instruction_valid (instr_valid),
        .i_cpsr_ff_t         (cpsr_t),
        .o_instruction       (out_instr),
        .o_instruction_valid (out_valid),
        .o_und               (out_und)
);

`include "thumb_ref_model.svh"

initial
begin
        clk = 1'b0;
        forever #4 clk = ~clk;          // 8 ns period
end

// Run limit
initial
        cycle_count = 0;

always @(posedge clk)
begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
                $display("Timeout, run did not finish within %0d cycles", cycle_limit);
                $display("SOME TESTS FAILED");
                $fatal(1, "Run limit reached");
        end
end

////////////////////////////////////////
// Check and drive helpers
////////////////////////////////////////

task automatic check_equal(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
        if (actual !== expected)
        begin
                $display("FAILED at %0t: %s actual 0x%0h expected 0x%0h",
                         $time, name, actual, expected);
                $display("SOME TESTS FAILED");
                $fatal(1, "Mismatch on %s", name);
        end
endtask

// Called at a falling edge, checks at the next one
task automatic drive_and_check(input logic [31:0] word, input logic valid,
                               input logic t_bit, input logic [34:0] exp_word,
                               input logic exp_valid, input logic exp_und);
        instr       = word;
        instr_valid = valid;
        cpsr_t      = t_bit;
        @(negedge clk);
        check_equal("o_instruction", out_instr, exp_word);
        check_equal("o_instruction_valid", out_valid, exp_valid);
        check_equal("o_und", out_und, exp_und);
endtask

// Thumb halfword, random upper half is ignored
task automatic run_thumb(input logic [15:0] hw, input logic [34:0] exp_word);
        logic [31:0] r;
        r = $urandom;
        drive_and_check({r[31:16], hw}, 1'b1, 1'b1, exp_word, 1'b1, 1'b0);
endtask

////////////////////////////////////////
// Directed tests
////////////////////////////////////////

task automatic test_reset_state();
        check_equal("o_instruction_valid", out_valid, 1'b0);
        check_equal("o_und", out_und, 1'b0);
        check_equal("o_instruction", out_instr, 35'd0);
        drive_and_check(32'd0, 1'b0, 1'b0, 35'd0, 1'b0, 1'b0);  // Idle cycle
endtask

task automatic test_arm_pass();
        logic [31:0] r;
        for (int i = 0; i < 14; i++)
        begin
                r = $urandom;
                // Valid low for the tail, T bit set on the last two bubbles
                drive_and_check(r, i < 8, i >= 12, {3'b000, r}, i < 8, 1'b0);
        end
endtask

task automatic test_data_processing();
        logic [31:0] r;
        logic [15:0] hw;
        for (int i = 0; i < 6; i++)
        begin
                r  = $urandom;
                hw = {3'b000, 2'($urandom_range(2, 0)), r[10:0]};      // Op 3 is ADD/SUB
                run_thumb(hw, exp_shift(hw));
        end
        for (int i = 0; i < 8; i++)
        begin
                r  = $urandom;
                hw = {5'b00011, r[10:0]};
                run_thumb(hw, exp_add_sub(hw));
        end
        for (int i = 0; i < 8; i++)
        begin
                r  = $urandom;
                hw = {3'b001, r[12:0]};
                run_thumb(hw, exp_mcas(hw));
        end
        for (int op = 0; op < 32; op++)
        begin
                r  = $urandom;
                hw = {6'b010000, 4'(op / 2), r[5:0]};   // Each ALU op twice
                run_thumb(hw, exp_alu_lo(hw));
        end
        for (int op = 0; op < 6; op++)
        begin
                r  = $urandom;
                hw = {6'b010001, 2'(op / 2), r[7:0]};
                run_thumb(hw, exp_alu_hi(hw));
        end
endtask

task automatic test_branches();
        logic [31:0] r;
        logic [15:0] hw;
        for (int i = 0; i < 4; i++)
        begin
                r  = $urandom;
                hw = {4'b1101, 4'($urandom_range(14, 0)), i[0], r[6:0]};  // Cond 15 is SWI
                run_thumb(hw, exp_branch_cond(hw));
                hw = {5'b11100, i[0], r[9:0]};                  // Sign alternates
                run_thumb(hw, exp_branch_uncond(hw));
        end
endtask

task automatic test_swi_bx();
        logic [31:0] r;
        logic [15:0] hw;
        for (int i = 0; i < 3; i++)
        begin
                r  = $urandom;
                hw = {8'hDF, r[7:0]};
                run_thumb(hw, exp_swi(hw));
                hw = {9'b0100_0111_0, r[11:8], 3'b000};
                run_thumb(hw, exp_bx(hw));
        end
endtask

task automatic test_undefined();
        logic [31:0] r;
        logic [31:0] word;
        r    = $urandom;
        word = {r[31:16], 5'b01100, r[10:0]};           // STR/LDR word imm
        drive_and_check(word, 1'b1, 1'b1, {3'b000, word}, 1'b1, 1'b1);
        word = {r[31:16], 5'b11110, r[10:0]};           // BL prefix
        drive_and_check(word, 1'b1, 1'b1, {3'b000, word}, 1'b1, 1'b1);
        word = {r[31:16], 9'b0100_0111_1, r[3:0], 3'b000};      // BLX2
        drive_and_check(word, 1'b1, 1'b1, {3'b000, word}, 1'b1, 1'b1);
endtask

initial
begin
        rst_n       = 1'b0;
        instr       = 32'd0;
        instr_valid = 1'b0;
        cpsr_t      = 1'b0;
        seed        = $urandom(53);     // Fixed seed
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset_state();
        test_arm_pass();
        test_data_processing();
        test_branches();
        test_swi_bx();
        test_undefined();

        $display("ALL TESTS PASSED");
        $finish;
end

endmodule

/* build.f */
+incdir+rtl
+incdir+tb
rtl/thumb_decoder_pkg.sv
rtl/thumb_classify.sv
rtl/thumb_dp_expand.sv
rtl/thumb_branch_expand.sv
rtl/thumb_decode_reg.sv
rtl/thumb_decoder_top.sv
tb/tb_thumb_decoder.sv
